/* logic/exu_types_pkg.sv */
/* Shared data types of the execution stage:
 * data word, CSR address, privilege level, instruction packet,
 * exception causes and the CSR address map */

package exu_types_pkg;

    // Operand and result word of every functional unit
    typedef logic [31:0] data_word_t;

    // CSR address as taken from the low bits of the second operand
    typedef logic [11:0] csr_address_t;

    // Current privilege, there is no supervisor level in this core
    typedef logic privilege_t;

    localparam privilege_t PRIV_USER    = 1'b0;
    localparam privilege_t PRIV_MACHINE = 1'b1;

    // Reorder buffer entry that the instruction belongs to
    typedef logic [3:0] rob_tag_t;

    // Exception cause as written into the instruction packet
    typedef logic [4:0] exception_code_t;

    localparam exception_code_t INSTR_ILLEGAL = 5'd2;

    // Bookkeeping that travels alongside each instruction
    typedef struct packed {
        rob_tag_t        rob_tag;
        data_word_t      pc;
        logic            exception_generated;
        exception_code_t exception_vector;
    } instr_packet_t;

    // Implemented machine mode registers
    localparam csr_address_t CSR_MSTATUS  = 12'h300;
    localparam csr_address_t CSR_MISA     = 12'h301;
    localparam csr_address_t CSR_MSCRATCH = 12'h340;
    localparam csr_address_t CSR_MCYCLE   = 12'hB00;
    localparam csr_address_t CSR_MINSTRET = 12'hB02;

endpackage : exu_types_pkg

/* logic/exu_operations_pkg.sv */
/* Operation encodings of the execution stage:
 * integer and CSR operation enums, the per unit valid
 * strobes and the micro operation that selects the work */

package exu_operations_pkg;

    // Operations of the integer unit
    typedef enum logic [3:0] {
        ITU_ADD,
        ITU_SUB,
        ITU_AND,
        ITU_OR,
        ITU_XOR,
        ITU_SLL,
        ITU_SRL,
        ITU_SRA,
        ITU_SLT,
        ITU_SLTU,
        ITU_MUL
    } itu_op_t;

    // Read-modify-write flavours of a CSR access
    typedef enum logic [1:0] {
        CSR_SWAP,
        CSR_SET,
        CSR_CLEAR
    } csr_op_t;

    // One strobe per unit, the issue logic raises at most one of them
    typedef struct packed {
        logic itu;
        logic csr;
    } exu_valid_t;

    // Each unit reads only its own field
    typedef struct packed {
        itu_op_t itu;
        csr_op_t csr;
    } exu_uop_t;

endpackage : exu_operations_pkg

/* logic/integer_unit.sv */
/* Integer unit: add, sub, logic, shifts, set-less-than and the low
 * multiply, computed in one cycle and registered on the output */

`timescale 1ns/100ps

module integer_unit import exu_types_pkg::*; import exu_operations_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          valid_i,
    input  itu_op_t       operation_i,
    input  data_word_t    operand_1_i,
    input  data_word_t    operand_2_i,
    input  instr_packet_t ipacket_i,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          valid_o
);

//========================================
//  Datapath
//========================================

    logic [4:0] shift_amount;
    data_word_t product;
    data_word_t result_next;

    // Shifts only look at the low five bits of the second operand
    assign shift_amount = operand_2_i[4:0];

    // The upper half of the product is simply discarded
    assign product = operand_1_i * operand_2_i;

    always_comb begin : operation_select
        case (operation_i)
            ITU_ADD:  result_next = operand_1_i + operand_2_i;
            ITU_SUB:  result_next = operand_1_i - operand_2_i;
            ITU_AND:  result_next = operand_1_i & operand_2_i;
            ITU_OR:   result_next = operand_1_i | operand_2_i;
            ITU_XOR:  result_next = operand_1_i ^ operand_2_i;
            ITU_SLL:  result_next = operand_1_i << shift_amount;
            ITU_SRL:  result_next = operand_1_i >> shift_amount;

            // Sign bit is replicated into the vacated positions
            ITU_SRA:  result_next = $unsigned($signed(operand_1_i) >>> shift_amount);

            // Compares produce a plain 0 or 1
            ITU_SLT:  result_next = {31'b0, $signed(operand_1_i) < $signed(operand_2_i)};
            ITU_SLTU: result_next = {31'b0, operand_1_i < operand_2_i};
            ITU_MUL:  result_next = product;
            default:  result_next = '0;
        endcase
    end : operation_select

//========================================
//  Output stage
//========================================

    // A flush kills whatever is being issued in the same cycle
    always_ff @(posedge clk_i) begin : valid_stage
        if (reset_i | flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end : valid_stage

    // Result and packet only move when a new instruction arrives
    always_ff @(posedge clk_i) begin : payload_stage
        if (valid_i) begin
            result_o  <= result_next;
            ipacket_o <= ipacket_i;
        end
    end : payload_stage

endmodule : integer_unit

/* logic/control_status_registers.sv */
/* Control and status registers: mstatus, misa, mscratch and the
 * two counters, the read-modify-write path and the legality checks */

`timescale 1ns/100ps

module control_status_registers import exu_types_pkg::*; import exu_operations_pkg::*; #(
    parameter data_word_t MISA_VALUE = 32'h40001100
) (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          csr_access_i,
    input  csr_op_t       operation_i,
    input  csr_address_t  csr_address_i,
    input  data_word_t    csr_data_write_i,
    input  privilege_t    privilege_i,
    input  instr_packet_t ipacket_i,
    input  logic          retire_i,
    output data_word_t    csr_data_read_o,
    output instr_packet_t ipacket_o,
    output logic          illegal_access_o,
    output logic          valid_o,
    output logic          glb_int_enabled_o
);

//========================================
//  Read and legality
//========================================

    // Only the global interrupt enable of mstatus is implemented
    logic       mstatus_mie;
    data_word_t mscratch;
    data_word_t mcycle;
    data_word_t minstret;

    data_word_t csr_old;
    data_word_t csr_new;
    logic       unknown_address;
    logic       read_only;
    logic       write_request;
    logic       illegal_access;
    logic       write_enable;

    always_comb begin : read_mux
        unknown_address = 1'b0;
        case (csr_address_i)
            CSR_MSTATUS:  csr_old = {28'b0, mstatus_mie, 3'b0};
            CSR_MISA:     csr_old = MISA_VALUE;
            CSR_MSCRATCH: csr_old = mscratch;
            CSR_MCYCLE:   csr_old = mcycle;
            CSR_MINSTRET: csr_old = minstret;
            default: begin
                csr_old         = '0;
                unknown_address = 1'b1;
            end
        endcase
    end : read_mux

    always_comb begin : modify
        case (operation_i)
            CSR_SWAP:  csr_new = csr_data_write_i;
            CSR_SET:   csr_new = csr_old | csr_data_write_i;
            CSR_CLEAR: csr_new = csr_old & ~csr_data_write_i;
            default:   csr_new = csr_old;
        endcase
    end : modify

    // Set and clear with a zero mask are pure reads and never write
    assign write_request = (operation_i == CSR_SWAP) | (|csr_data_write_i);

    // Addresses with bits 11:10 set are read only and misa is fixed in this core
    assign read_only = (&csr_address_i[11:10]) | (csr_address_i == CSR_MISA);

    // Bits 9:8 hold the lowest privilege allowed to touch the register
    assign illegal_access = unknown_address
                          | (read_only & write_request)
                          | ((privilege_i == PRIV_USER) & (|csr_address_i[9:8]));

    assign write_enable = csr_access_i & write_request & ~illegal_access & ~flush_i;

//========================================
//  Register storage
//========================================

    always_ff @(posedge clk_i) begin : storage
        if (reset_i) begin
            mstatus_mie <= 1'b0;
            mscratch    <= '0;
        end else if (write_enable) begin
            case (csr_address_i)
                CSR_MSTATUS:  mstatus_mie <= csr_new[3];
                CSR_MSCRATCH: mscratch    <= csr_new;
                default: ;
            endcase
        end
    end : storage

    // A software write always wins over the automatic increment
    always_ff @(posedge clk_i) begin : counters
        if (reset_i) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (write_enable & (csr_address_i == CSR_MCYCLE)) begin
                mcycle <= csr_new;
            end else begin
                mcycle <= mcycle + 32'd1;
            end

            if (write_enable & (csr_address_i == CSR_MINSTRET)) begin
                minstret <= csr_new;
            end else if (retire_i) begin
                minstret <= minstret + 32'd1;
            end
        end
    end : counters

    assign glb_int_enabled_o = mstatus_mie;

//========================================
//  Output stage
//========================================

    always_ff @(posedge clk_i) begin : valid_stage
        if (reset_i | flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= csr_access_i;
        end
    end : valid_stage

    // The old value is captured at issue and an illegal access reads zero
    always_ff @(posedge clk_i) begin : payload_stage
        if (csr_access_i) begin
            csr_data_read_o  <= illegal_access ? '0 : csr_old;
            ipacket_o        <= ipacket_i;
            illegal_access_o <= illegal_access;
        end
    end : payload_stage

endmodule : control_status_registers

/* logic/result_merge.sv */
/* Result merge: picks the valid unit lane, tags illegal CSR
 * accesses, registers the result and signals instruction retire */

`timescale 1ns/100ps

module result_merge import exu_types_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          itu_valid_i,
    input  data_word_t    itu_result_i,
    input  instr_packet_t itu_ipacket_i,
    input  logic          csr_valid_i,
    input  data_word_t    csr_result_i,
    input  instr_packet_t csr_ipacket_i,
    input  logic          csr_illegal_i,
    output data_word_t    result_o,
    output instr_packet_t ipacket_o,
    output logic          data_valid_o,
    output logic          retire_o
);

    data_word_t    result_next;
    instr_packet_t ipacket_next;

    // Lanes are never valid together, so a priority mux is enough
    always_comb begin : lane_select
        result_next  = '0;
        ipacket_next = '0;

        if (itu_valid_i) begin
            result_next  = itu_result_i;
            ipacket_next = itu_ipacket_i;
        end else if (csr_valid_i) begin
            result_next  = csr_result_i;
            ipacket_next = csr_ipacket_i;

            // Bad address, read-only write or too low privilege
            if (csr_illegal_i) begin
                ipacket_next.exception_generated = 1'b1;
                ipacket_next.exception_vector    = INSTR_ILLEGAL;
            end
        end
    end : lane_select

    always_ff @(posedge clk_i) begin : valid_stage
        if (reset_i | flush_i) begin
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= itu_valid_i | csr_valid_i;
        end
    end : valid_stage

    always_ff @(posedge clk_i) begin : payload_stage
        result_o  <= result_next;
        ipacket_o <= ipacket_next;
    end : payload_stage

    // Every result that leaves the stage counts as retired
    assign retire_o = data_valid_o;

endmodule : result_merge

/* logic/execution_unit.sv */
/* Execution stage top level: integer unit and CSR unit side by
 * side, followed by the result merge stage */

`timescale 1ns/100ps

module execution_unit import exu_types_pkg::*; import exu_operations_pkg::*; #(
    parameter data_word_t MISA_VALUE = 32'h40001100
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             flush_i,
    input  data_word_t [1:0] operand_i,
    input  exu_valid_t       data_valid_i,
    input  exu_uop_t         operation_i,
    input  instr_packet_t    ipacket_i,
    input  privilege_t       privilege_i,
    output data_word_t       result_o,
    output instr_packet_t    ipacket_o,
    output logic             data_valid_o,
    output logic             glb_interrupt_enable_o
);

//========================================
//  Functional units
//========================================

    data_word_t    itu_result;
    instr_packet_t itu_ipacket;
    logic          itu_valid;

    integer_unit ITU (
        .clk_i       ( clk_i           ),
        .reset_i     ( reset_i         ),
        .flush_i     ( flush_i         ),
        .valid_i     ( data_valid_i.itu ),
        .operation_i ( operation_i.itu ),
        .operand_1_i ( operand_i[0]    ),
        .operand_2_i ( operand_i[1]    ),
        .ipacket_i   ( ipacket_i       ),
        .result_o    ( itu_result      ),
        .ipacket_o   ( itu_ipacket     ),
        .valid_o     ( itu_valid       )
    );

    data_word_t    csr_result;
    instr_packet_t csr_ipacket;
    logic          csr_illegal;
    logic          csr_valid;
    logic          retire;

    // Operand 0 is the write data, operand 1 carries the CSR address
    control_status_registers #(
        .MISA_VALUE ( MISA_VALUE )
    ) CSRU (
        .clk_i             ( clk_i                  ),
        .reset_i           ( reset_i                ),
        .flush_i           ( flush_i                ),
        .csr_access_i      ( data_valid_i.csr       ),
        .operation_i       ( operation_i.csr        ),
        .csr_address_i     ( operand_i[1][11:0]     ),
        .csr_data_write_i  ( operand_i[0]           ),
        .privilege_i       ( privilege_i            ),
        .ipacket_i         ( ipacket_i              ),
        .retire_i          ( retire                 ),
        .csr_data_read_o   ( csr_result             ),
        .ipacket_o         ( csr_ipacket            ),
        .illegal_access_o  ( csr_illegal            ),
        .valid_o           ( csr_valid              ),
        .glb_int_enabled_o ( glb_interrupt_enable_o )
    );

//========================================
//  Result merge
//========================================

    result_merge MRG (
        .clk_i         ( clk_i        ),
        .reset_i       ( reset_i      ),
        .flush_i       ( flush_i      ),
        .itu_valid_i   ( itu_valid    ),
        .itu_result_i  ( itu_result   ),
        .itu_ipacket_i ( itu_ipacket  ),
        .csr_valid_i   ( csr_valid    ),
        .csr_result_i  ( csr_result   ),
        .csr_ipacket_i ( csr_ipacket  ),
        .csr_illegal_i ( csr_illegal  ),
        .result_o      ( result_o     ),
        .ipacket_o     ( ipacket_o    ),
        .data_valid_o  ( data_valid_o ),
        .retire_o      ( retire       )
    );

endmodule : execution_unit

/* bench/execution_unit_props.sv */
/* Concurrent checks of the execution stage: one busy unit
 * at a time, flush clearing and the two cycle latency */

`timescale 1ns/100ps

module execution_unit_props import exu_operations_pkg::*; (
    input logic       clk_i,
    input logic       reset_i,
    input logic       flush_i,
    input exu_valid_t issue_valid_i,
    input logic       itu_valid_i,
    input logic       csr_valid_i,
    input logic       result_valid_i
);

    // Number of assertion failures so far
    int unsigned assertion_failures = 0;

    // Unit stages follow the issue strobes and must never overlap
    single_unit_stage: assert property (@(posedge clk_i) disable iff (reset_i)
        !(itu_valid_i && csr_valid_i))
    else begin
        assertion_failures++;
        $error("both unit stages hold a valid result");
    end

    flush_clears_output: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |=> !result_valid_i)
    else begin
        assertion_failures++;
        $error("output still valid in the cycle after a flush");
    end

    // A flush at the issue edge or at the merge edge cancels the result
    fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i == ($past(|issue_valid_i, 2) && !$past(flush_i, 2)
                           && !$past(flush_i, 1)))
    else begin
        assertion_failures++;
        $error("output valid does not trail the issue by two cycles");
    end

endmodule : execution_unit_props

/* bench/execution_unit_tb.sv */
/* Testbench of the execution stage: clock and reset, data file reader,
 * stimulus, result checks, timeout and the closing summary */

`timescale 1ns/100ps

module execution_unit_tb import exu_types_pkg::*; import exu_operations_pkg::*; ();

    localparam int MAX_LINES   = 64;
    localparam int FIELDS      = 8;
    localparam int DRIVE_DELAY = 10;

    // Column positions of one line in the data file
    localparam int F_UNIT      = 0;
    localparam int F_OP        = 1;
    localparam int F_OPERAND_0 = 2;
    localparam int F_OPERAND_1 = 3;
    localparam int F_PRIVILEGE = 4;
    localparam int F_FLUSH     = 5;
    localparam int F_RESULT    = 6;
    localparam int F_EXCEPTION = 7;

    logic             clk_i;
    logic             reset_i;
    logic             flush_i;
    data_word_t [1:0] operand_i;
    exu_valid_t       data_valid_i;
    exu_uop_t         operation_i;
    instr_packet_t    ipacket_i;
    privilege_t       privilege_i;
    data_word_t       result_o;
    instr_packet_t    ipacket_o;
    logic             data_valid_o;
    logic             glb_interrupt_enable_o;

    data_word_t  test_words [0:MAX_LINES*FIELDS-1];
    int          error_count;
    int          current_line;
    int          cycle_count;
    int          timeout_cycles;
    int unsigned property_failures;

    execution_unit execution_unit_i (
        .clk_i                  ( clk_i                  ),
        .reset_i                ( reset_i                ),
        .flush_i                ( flush_i                ),
        .operand_i              ( operand_i              ),
        .data_valid_i           ( data_valid_i           ),
        .operation_i            ( operation_i            ),
        .ipacket_i              ( ipacket_i              ),
        .privilege_i            ( privilege_i            ),
        .result_o               ( result_o               ),
        .ipacket_o              ( ipacket_o              ),
        .data_valid_o           ( data_valid_o           ),
        .glb_interrupt_enable_o ( glb_interrupt_enable_o )
    );

    // Internal unit strobes are picked up inside the DUT scope
    bind execution_unit execution_unit_props props_i (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .flush_i        ( flush_i      ),
        .issue_valid_i  ( data_valid_i ),
        .itu_valid_i    ( itu_valid    ),
        .csr_valid_i    ( csr_valid    ),
        .result_valid_i ( data_valid_o )
    );

//========================================
//  Clock and timeout
//========================================

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end : clock_gen

    // Limit follows from two cycles per line plus reset and drain
    always @(posedge clk_i) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end : watchdog

//========================================
//  Helpers
//========================================

    task automatic check_value(input string name, input data_word_t actual,
                               input data_word_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error: line %0d %s = 0x%08h, expected 0x%08h",
                     current_line, name, actual, expected);
        end
    endtask

    function automatic data_word_t line_field(input int line, input int position);
        return test_words[line * FIELDS + position];
    endfunction

    function automatic data_word_t line_pc(input int line);
        return 32'h8000_0000 + 32'(line) * 32'd4;
    endfunction

    // Register contents after swap, set or clear of the old value
    function automatic data_word_t csr_written_value(input data_word_t op,
            input data_word_t old_value, input data_word_t operand);
        case (op[1:0])
            2'd0:    return operand;
            2'd1:    return old_value | operand;
            default: return old_value & ~operand;
        endcase
    endfunction

    // Lines run until the end marker, whose unit column is 0
    function automatic int count_lines();
        int n;
        n = 0;
        while ((n < MAX_LINES) && ((test_words[n * FIELDS] === 32'd1)
                || (test_words[n * FIELDS] === 32'd2))) begin
            n++;
        end
        return n;
    endfunction

    task automatic drive_idle();
        data_valid_i = '0;
        flush_i      = 1'b0;
        operand_i    = '0;
        operation_i  = '{itu: ITU_ADD, csr: CSR_SWAP};
        ipacket_i    = '0;
        privilege_i  = PRIV_MACHINE;
    endtask

    task automatic drive_line(input int idx);
        data_word_t unit;
        data_word_t op;
        data_word_t level;
        data_word_t flush;
        unit  = line_field(idx, F_UNIT);
        op    = line_field(idx, F_OP);
        level = line_field(idx, F_PRIVILEGE);
        flush = line_field(idx, F_FLUSH);

        // Unit column 2 raises the integer strobe, 1 the CSR strobe
        data_valid_i    = exu_valid_t'(unit[1:0]);
        operation_i.itu = itu_op_t'(op[3:0]);
        operation_i.csr = csr_op_t'(op[1:0]);
        operand_i[0]    = line_field(idx, F_OPERAND_0);
        operand_i[1]    = line_field(idx, F_OPERAND_1);
        privilege_i     = privilege_t'(level[0]);
        flush_i         = flush[0];

        ipacket_i.rob_tag             = 4'(idx);
        ipacket_i.pc                  = line_pc(idx);
        ipacket_i.exception_generated = 1'b0;
        ipacket_i.exception_vector    = '0;
    endtask

    task automatic check_line(input int idx);
        data_word_t unit;
        data_word_t exc;
        data_word_t flush;
        data_word_t address;
        data_word_t new_status;
        unit    = line_field(idx, F_UNIT);
        exc     = line_field(idx, F_EXCEPTION);
        flush   = line_field(idx, F_FLUSH);
        address = line_field(idx, F_OPERAND_1);
        current_line = idx;

        if (flush[0]) begin
            // A flushed issue must never reach the output
            check_value("data_valid_o", 32'(data_valid_o), 32'd0);
        end else begin
            check_value("data_valid_o", 32'(data_valid_o), 32'd1);
            check_value("result_o", result_o, line_field(idx, F_RESULT));
            check_value("rob_tag", 32'(ipacket_o.rob_tag), 32'(idx[3:0]));
            check_value("pc", ipacket_o.pc, line_pc(idx));
            check_value("exception_generated", 32'(ipacket_o.exception_generated), exc);
            check_value("exception_vector", 32'(ipacket_o.exception_vector),
                        exc[0] ? 32'(INSTR_ILLEGAL) : 32'd0);

            // Interrupt enable mirrors bit 3 of the freshly written mstatus
            if ((unit == 32'd1) && (exc == 32'd0) && (address[11:0] == CSR_MSTATUS)) begin
                new_status = csr_written_value(line_field(idx, F_OP),
                                               line_field(idx, F_RESULT),
                                               line_field(idx, F_OPERAND_0));
                check_value("glb_interrupt_enable_o", 32'(glb_interrupt_enable_o),
                            32'(new_status[3]));
            end
        end
    endtask

//========================================
//  Test sequence
//========================================

    initial begin : run_tests
        int line_count;
        reset_i           = 1'b1;
        error_count       = 0;
        current_line      = 0;
        cycle_count       = 0;
        property_failures = 0;
        drive_idle();

        $readmemh("bench/execution_unit_testdata.txt", test_words);
        line_count     = count_lines();
        timeout_cycles = line_count * 2 + 20;
        if (line_count == 0) begin
            error_count++;
            $display("No test lines could be read from the data file");
        end

        repeat (3) @(posedge clk_i);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        // Each issue is checked two edges later, when the next line goes out
        for (int i = 0; i < line_count; i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            if (i > 0) begin
                check_line(i - 1);
            end
            drive_line(i);

            @(posedge clk_i);
            #DRIVE_DELAY;
            // The output now belongs to the idle slot before this issue
            current_line = i;
            check_value("data_valid_o", 32'(data_valid_o), 32'd0);
            drive_idle();
        end

        if (line_count > 0) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            check_line(line_count - 1);
        end

        property_failures = execution_unit_i.props_i.assertion_failures;
        $display("Ran %0d lines with %0d value errors and %0d assertion failures",
                 line_count, error_count, property_failures);
        if ((error_count == 0) && (property_failures == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end : run_tests

endmodule : execution_unit_tb

/* bench/execution_unit_testdata.txt */
// unit(2 integer, 1 csr, 0 end) op operand_0 operand_1 privilege(1 machine) flush result exception
// For csr lines operand_0 is the write data and operand_1 the address
2 0 7fffffff 00000001 1 0 80000000 0
2 1 00000005 00000007 1 0 fffffffe 0
2 2 f0f0f0f0 3c3c3c3c 1 0 30303030 0
2 3 f0f0f0f0 0f0000ff 1 0 fff0f0ff 0
2 4 aaaa5555 ffff0000 1 0 55555555 0
2 5 00000003 00000024 1 0 00000030 0
2 6 80000000 0000001f 1 0 00000001 0
2 7 80000000 00000004 1 0 f8000000 0
2 8 ffffffff 00000001 1 0 00000001 0
2 9 ffffffff 00000001 0 0 00000000 0
2 a 00012345 00010000 1 0 23450000 0
1 0 deadbeef 00000340 1 0 00000000 0
1 1 00000008 00000300 1 0 00000000 0
1 1 00000000 00000300 1 0 00000008 0
1 2 00000008 00000300 1 0 00000008 0
1 2 0000ffff 00000340 1 0 deadbeef 0
1 1 00000000 00000340 1 0 dead0000 0
1 0 12345678 00000340 0 0 00000000 1
1 0 00000000 00000301 1 0 00000000 1
1 1 00000000 00000301 1 0 40001100 0
1 1 00000000 000007c0 1 0 00000000 1
1 0 0badf00d 00000340 1 1 00000000 0
1 1 00000000 00000340 1 0 dead0000 0
1 1 00000000 00000b02 1 0 00000015 0
1 0 00000100 00000b02 1 0 00000016 0
1 1 00000000 00000b02 1 0 00000100 0
0 0 00000000 00000000 0 0 00000000 0

/* execution_unit.f */
logic/exu_types_pkg.sv
logic/exu_operations_pkg.sv
logic/integer_unit.sv
logic/control_status_registers.sv
logic/result_merge.sv
logic/execution_unit.sv
bench/execution_unit_props.sv
bench/execution_unit_tb.sv

/* Makefile */
# Verilator simulation of the execution stage
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := execution_unit_tb
FILE_LIST := execution_unit.f
PASS_TEXT := All tests passed!

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
